// File: msx_cas_consts.svh
//==========================================================================
// Cassette path constants
// Widths, the CAS download index and the tape bit timing shared by
// the loader, the byte buffer and the tape player
//==========================================================================

`ifndef MSX_CAS_CONSTS_SVH
`define MSX_CAS_CONSTS_SVH

// Buffer address width, 4096 bytes at 12
`define CAS_ADDR_W 12

// Host download index that carries a CAS image
`define CAS_IOCTL_INDEX 5

// Host download address width
`define IOCTL_ADDR_W 27

// clk21m cycles per tape clock enable
`define CE_DIV 4

// Tape clock enables per serialized bit, 32 clk21m cycles in total
`define BIT_TICKS 8

`endif

// File: cas_mem_pkg.sv
//==========================================================================
// Cassette buffer types
// Address, length and byte types of the CAS image buffer plus the
// decoded host download index
//==========================================================================

`include "msx_cas_consts.svh"

package cas_mem_pkg;

   // Byte address inside the image buffer
   typedef logic [`CAS_ADDR_W-1:0] cas_addr_t;

   // Image length, one bit wider to hold a full buffer
   typedef logic [`CAS_ADDR_W:0] cas_len_t;

   // One image byte
   typedef logic [7:0] cas_byte_t;

   // Download index, low six bits of the host index
   typedef enum logic [5:0] {
      IDX_OTHER = 6'd0,
      IDX_CAS   = 6'(`CAS_IOCTL_INDEX)
   } ioctl_index_e;

endpackage

// File: tape_pkg.sv
//==========================================================================
// Tape player types
// Player FSM states and the cassette input source select
//==========================================================================

package tape_pkg;

   // Player FSM
   typedef enum logic [2:0] {
      TP_IDLE  = 3'd0,
      TP_FETCH = 3'd1,
      TP_WAIT  = 3'd2,
      TP_SHIFT = 3'd3,
      TP_END   = 3'd4
   } tape_state_e;

   // Cassette input source
   typedef enum logic {
      CAS_AUDIO_FILE = 1'b0,
      CAS_AUDIO_ADC  = 1'b1
   } cas_audio_src_e;

endpackage

// File: cas_loader.sv
`timescale 1ns/10ps
//==========================================================================
// CAS image loader
// Takes host download writes tagged with the CAS index, turns them
// into registered buffer writes and tracks the image length
//==========================================================================

`include "msx_cas_consts.svh"

module cas_loader (
   input  logic                     clk21m,
   input  logic                     rst_n,
   input  logic                     ioctl_download,
   input  logic [15:0]              ioctl_index,
   input  logic                     ioctl_wr,
   input  logic [`IOCTL_ADDR_W-1:0] ioctl_addr,
   input  cas_mem_pkg::cas_byte_t   ioctl_dout,
   output logic                     wr_en,
   output cas_mem_pkg::cas_addr_t   wr_addr,
   output cas_mem_pkg::cas_byte_t   wr_data,
   output logic                     load_start,
   output cas_mem_pkg::cas_len_t    img_len
);
   import cas_mem_pkg::*;

   ioctl_index_e idx;
   logic         is_cas;
   logic         is_cas_q;
   logic         accept;
   cas_len_t     wr_end;

   // Index decode, only the low six bits matter
   assign idx    = (ioctl_index[5:0] == IDX_CAS) ? IDX_CAS : IDX_OTHER;
   assign is_cas = ioctl_download && (idx == IDX_CAS);
   assign accept = is_cas && ioctl_wr;

   // Download edge and write strobe
   always_ff @(posedge clk21m or negedge rst_n) begin
      if (!rst_n) begin
         is_cas_q   <= 1'b0;
         load_start <= 1'b0;
         wr_en      <= 1'b0;
      end else begin
         is_cas_q   <= is_cas;
         // One pulse as a CAS download opens
         load_start <= is_cas && !is_cas_q;
         wr_en      <= accept;
      end
   end

   // Write payload
   always_ff @(posedge clk21m) begin
      if (accept) begin
         wr_addr <= ioctl_addr[`CAS_ADDR_W-1:0];
         wr_data <= ioctl_dout;
      end
   end

   // Byte count implied by the current write
   assign wr_end = cas_len_t'(wr_addr) + cas_len_t'(1);

   // Image length, highest written address plus one
   always_ff @(posedge clk21m or negedge rst_n) begin
      if (!rst_n) begin
         img_len <= '0;
      end else if (load_start) begin
         // First byte may land together with the start pulse
         img_len <= wr_en ? wr_end : '0;
      end else if (wr_en && (wr_end > img_len)) begin
         img_len <= wr_end;
      end
   end

   // Host must not send more than the buffer holds
   a_addr_in_buffer: assert property (@(posedge clk21m) disable iff (!rst_n)
      accept |-> ((ioctl_addr >> `CAS_ADDR_W) == '0));

endmodule

// File: cas_buffer.sv
`timescale 1ns/10ps
//==========================================================================
// CAS byte buffer
// Single image memory with a write port from the loader and a rd/ready
// read port for the tape player. Writes own the array, so a read waits
// for a write-free cycle and ready marks its completion
//==========================================================================

`include "msx_cas_consts.svh"

module cas_buffer (
   input  logic                   clk21m,
   input  logic                   rst_n,
   input  logic                   wr_en,
   input  cas_mem_pkg::cas_addr_t wr_addr,
   input  cas_mem_pkg::cas_byte_t wr_data,
   input  logic                   rd,
   input  cas_mem_pkg::cas_addr_t rd_addr,
   output cas_mem_pkg::cas_byte_t rd_data,
   output logic                   ready
);
   import cas_mem_pkg::*;

   localparam int DEPTH = 1 << `CAS_ADDR_W;

   cas_byte_t mem [DEPTH];
   logic      pend;
   cas_addr_t pend_addr;
   logic      rd_go;

   // Array access for the held read, blocked by writes
   assign rd_go = pend && !wr_en;

   // Write port
   always_ff @(posedge clk21m) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // Stage one, latch the request address
   always_ff @(posedge clk21m) begin
      if (rd) begin
         pend_addr <= rd_addr;
      end
   end

   // Stage two, array read
   always_ff @(posedge clk21m) begin
      if (rd_go) begin
         rd_data <= mem[pend_addr];
      end
   end

   // Request tracking and ready pulse
   always_ff @(posedge clk21m or negedge rst_n) begin
      if (!rst_n) begin
         pend  <= 1'b0;
         ready <= 1'b0;
      end else begin
         ready <= rd_go;
         if (rd) begin
            pend <= 1'b1;
         end else if (rd_go) begin
            pend <= 1'b0;
         end
      end
   end

   // Player waits for ready before the next request
   a_no_rd_while_pend: assert property (@(posedge clk21m) disable iff (!rst_n)
      rd |-> !pend);

endmodule

// File: tape_player.sv
`timescale 1ns/10ps
//==========================================================================
// CAS tape player
// Fetches image bytes over the buffer rd/ready port and shifts them out
// MSB first, one bit per 32 clk21m cycles while the motor runs.
// The next byte is prefetched during the last bit of the current one.
// Output source is either this playback or the ADC tape bit
//==========================================================================

`include "msx_cas_consts.svh"

module tape_player (
   input  logic                     clk21m,
   input  logic                     rst_n,
   input  logic                     load_start,
   input  cas_mem_pkg::cas_len_t    img_len,
   input  logic                     rewind_req,
   input  logic                     cas_motor_n,
   input  tape_pkg::cas_audio_src_e audio_src,
   input  logic                     tape_adc,
   input  logic                     tape_adc_act,
   input  cas_mem_pkg::cas_byte_t   rd_data,
   input  logic                     ready,
   output logic                     rd,
   output cas_mem_pkg::cas_addr_t   rd_addr,
   output logic                     cas_audio_in
);
   import cas_mem_pkg::*;
   import tape_pkg::*;

   localparam int CE_W   = $clog2(`CE_DIV);
   localparam int TICK_W = $clog2(`BIT_TICKS);

   tape_state_e       state;
   logic              play;
   logic              rewind;
   logic              more;
   logic              ce;
   logic              bit_end;
   logic              last_bit;
   logic [CE_W-1:0]   ce_cnt;
   logic [TICK_W-1:0] tick_cnt;
   logic [2:0]        bit_cnt;
   cas_byte_t         shift_q;
   cas_byte_t         nxt_byte;
   logic              nxt_valid;
   logic              pf_pend;
   logic              rd_busy;
   cas_len_t          nxt_addr;
   logic              file_bit;

   // Motor line is active low
   assign play   = ~cas_motor_n;
   assign rewind = rewind_req | load_start;
   assign more   = nxt_addr < img_len;

   //==========================================================================
   // Bit timing
   //==========================================================================

   // Divider and tick counter only move while shifting with motor on
   assign ce       = play && (state == TP_SHIFT) && (ce_cnt == CE_W'(`CE_DIV - 1));
   assign bit_end  = ce && (tick_cnt == TICK_W'(`BIT_TICKS - 1));
   assign last_bit = (bit_cnt == 3'd7);

   always_ff @(posedge clk21m or negedge rst_n) begin
      if (!rst_n) begin
         ce_cnt   <= '0;
         tick_cnt <= '0;
      end else if (rewind || (state != TP_SHIFT)) begin
         ce_cnt   <= '0;
         tick_cnt <= '0;
      end else if (play) begin
         ce_cnt <= ce ? '0 : ce_cnt + 1'b1;
         if (ce) begin
            tick_cnt <= bit_end ? '0 : tick_cnt + 1'b1;
         end
      end
   end

   // Outstanding read, kept across rewind so a late reply is not reused
   always_ff @(posedge clk21m or negedge rst_n) begin
      if (!rst_n) begin
         rd_busy <= 1'b0;
      end else if (rd) begin
         rd_busy <= 1'b1;
      end else if (ready) begin
         rd_busy <= 1'b0;
      end
   end

   //==========================================================================
   // Player FSM
   //==========================================================================

   always_ff @(posedge clk21m or negedge rst_n) begin
      if (!rst_n) begin
         state     <= TP_IDLE;
         rd        <= 1'b0;
         rd_addr   <= '0;
         nxt_addr  <= '0;
         nxt_valid <= 1'b0;
         pf_pend   <= 1'b0;
         bit_cnt   <= '0;
      end else begin
         rd <= 1'b0;
         if (rewind) begin
            state     <= TP_IDLE;
            rd_addr   <= '0;
            nxt_addr  <= '0;
            nxt_valid <= 1'b0;
            pf_pend   <= 1'b0;
            bit_cnt   <= '0;
         end else begin
            case (state)
               TP_IDLE: begin
                  if (play && (img_len != '0)) begin
                     state <= TP_FETCH;
                  end
               end
               // First byte after start or rewind
               TP_FETCH: begin
                  if (!rd_busy && !rd) begin
                     rd       <= 1'b1;
                     rd_addr  <= nxt_addr[`CAS_ADDR_W-1:0];
                     nxt_addr <= nxt_addr + 1'b1;
                     pf_pend  <= 1'b1;
                     state    <= TP_WAIT;
                  end
               end
               TP_WAIT: begin
                  if (ready) begin
                     pf_pend <= 1'b0;
                     bit_cnt <= '0;
                     state   <= TP_SHIFT;
                  end
               end
               TP_SHIFT: begin
                  // Prefetched byte arrives mid-bit
                  if (ready && pf_pend) begin
                     nxt_valid <= 1'b1;
                     pf_pend   <= 1'b0;
                  end
                  if (bit_end) begin
                     bit_cnt <= bit_cnt + 1'b1;
                     // Last bit starts, request the next byte
                     if ((bit_cnt == 3'd6) && more) begin
                        rd       <= 1'b1;
                        rd_addr  <= nxt_addr[`CAS_ADDR_W-1:0];
                        nxt_addr <= nxt_addr + 1'b1;
                        pf_pend  <= 1'b1;
                     end
                     if (last_bit) begin
                        if (nxt_valid || (ready && pf_pend)) begin
                           nxt_valid <= 1'b0;
                        end else if (pf_pend) begin
                           // Read held up by writes
                           state <= TP_WAIT;
                        end else begin
                           state <= TP_END;
                        end
                     end
                  end
               end
               TP_END: begin
                  state <= TP_END;
               end
               default: begin
                  state <= TP_IDLE;
               end
            endcase
         end
      end
   end

   // Shift register and prefetch holding byte
   always_ff @(posedge clk21m) begin
      if ((state == TP_WAIT) && ready) begin
         shift_q <= rd_data;
      end else if ((state == TP_SHIFT) && bit_end) begin
         if (!last_bit) begin
            shift_q <= {shift_q[6:0], 1'b0};
         end else if (nxt_valid) begin
            shift_q <= nxt_byte;
         end else if (ready) begin
            shift_q <= rd_data;
         end
      end
      if ((state == TP_SHIFT) && ready) begin
         nxt_byte <= rd_data;
      end
   end

   //==========================================================================
   // Output select
   //==========================================================================

   // Idle level is high
   assign file_bit     = (state == TP_SHIFT) ? shift_q[7] : 1'b1;
   assign cas_audio_in = (audio_src == CAS_AUDIO_FILE) ? file_bit
                                                       : (tape_adc & tape_adc_act);

endmodule

// File: msx_cas_top.sv
`timescale 1ns/10ps
//==========================================================================
// MSX cassette path
// Host CAS download into the byte buffer and tape playback into the
// cassette input, with file or ADC source select
//==========================================================================

`include "msx_cas_consts.svh"

module msx_cas_top (
   input  logic                     clk21m,
   input  logic                     rst_n,
   input  logic                     ioctl_download,
   input  logic [15:0]              ioctl_index,
   input  logic                     ioctl_wr,
   input  logic [`IOCTL_ADDR_W-1:0] ioctl_addr,
   input  cas_mem_pkg::cas_byte_t   ioctl_dout,
   input  logic                     rewind_req,
   input  logic                     cas_motor_n,
   input  tape_pkg::cas_audio_src_e audio_src,
   input  logic                     tape_adc,
   input  logic                     tape_adc_act,
   output logic                     cas_audio_in
);
   import cas_mem_pkg::*;

   // Loader to buffer
   logic      wr_en;
   cas_addr_t wr_addr;
   cas_byte_t wr_data;

   // Loader to player
   logic      load_start;
   cas_len_t  img_len;

   // Player read port
   logic      rd;
   cas_addr_t rd_addr;
   cas_byte_t rd_data;
   logic      ready;

   cas_loader u_loader (
      .clk21m         (clk21m),
      .rst_n          (rst_n),
      .ioctl_download (ioctl_download),
      .ioctl_index    (ioctl_index),
      .ioctl_wr       (ioctl_wr),
      .ioctl_addr     (ioctl_addr),
      .ioctl_dout     (ioctl_dout),
      .wr_en          (wr_en),
      .wr_addr        (wr_addr),
      .wr_data        (wr_data),
      .load_start     (load_start),
      .img_len        (img_len)
   );

   cas_buffer u_buffer (
      .clk21m  (clk21m),
      .rst_n   (rst_n),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .rd      (rd),
      .rd_addr (rd_addr),
      .rd_data (rd_data),
      .ready   (ready)
   );

   tape_player u_player (
      .clk21m       (clk21m),
      .rst_n        (rst_n),
      .load_start   (load_start),
      .img_len      (img_len),
      .rewind_req   (rewind_req),
      .cas_motor_n  (cas_motor_n),
      .audio_src    (audio_src),
      .tape_adc     (tape_adc),
      .tape_adc_act (tape_adc_act),
      .rd_data      (rd_data),
      .ready        (ready),
      .rd           (rd),
      .rd_addr      (rd_addr),
      .cas_audio_in (cas_audio_in)
   );

endmodule

// File: tb_msx_cas_top.sv
`timescale 1ns/10ps
//==========================================================================
// MSX cassette path testbench
// Directed tests for reset level, CAS load and playback, foreign download
// index, motor pause, rewind with reload and the ADC source select
//==========================================================================

`include "msx_cas_consts.svh"

module tb_msx_cas_top;
   import tape_pkg::*;

   // Bits played over all tests, plus a margin for downloads and idle checks
   localparam int IMG_BITS  = 128 * 3 + 44 + 32 + 64;
   localparam int SETUP_CYC = 1500;
   localparam int LIMIT     = 2 * (IMG_BITS * 32 + SETUP_CYC);

   logic                     clk21m = 1'b0;
   logic                     rst_n;
   logic                     ioctl_download;
   logic [15:0]              ioctl_index;
   logic                     ioctl_wr;
   logic [`IOCTL_ADDR_W-1:0] ioctl_addr;
   logic [7:0]               ioctl_dout;
   logic                     rewind_req;
   logic                     cas_motor_n;
   cas_audio_src_e           audio_src;
   logic                     tape_adc;
   logic                     tape_adc_act;
   logic                     cas_audio_in;

   integer     seed;
   int         cycle_cnt = 0;
   int         err_cnt   = 0;
   int         pass_cnt  = 0;
   int         fail_cnt  = 0;
   logic [7:0] img_a   [16];
   logic [7:0] img_b   [16];
   logic [7:0] img_c   [16];
   // Image the player should currently reproduce
   logic [7:0] exp_img [16];

   msx_cas_top uut (
      .clk21m         (clk21m),
      .rst_n          (rst_n),
      .ioctl_download (ioctl_download),
      .ioctl_index    (ioctl_index),
      .ioctl_wr       (ioctl_wr),
      .ioctl_addr     (ioctl_addr),
      .ioctl_dout     (ioctl_dout),
      .rewind_req     (rewind_req),
      .cas_motor_n    (cas_motor_n),
      .audio_src      (audio_src),
      .tape_adc       (tape_adc),
      .tape_adc_act   (tape_adc_act),
      .cas_audio_in   (cas_audio_in)
   );

   // 10 ns clock
   always #5 clk21m = ~clk21m;

   // Run limit
   always @(posedge clk21m) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt == LIMIT) begin
         $display("Run stopped, cycle limit of %0d reached", LIMIT);
         $display("test failed");
         $finish;
      end
   end

   //==========================================================================
   // Helpers
   //==========================================================================

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      if (got !== exp) begin
         $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
         err_cnt++;
      end
   endtask

   // Serial bit k of the expected image, MSB first
   function automatic logic image_bit(input int k);
      logic [7:0] b;
      b = exp_img[k / 8];
      return b[7 - (k % 8)];
   endfunction

   task automatic download_image(input logic [5:0] index, input logic [7:0] data [16],
                                 input int n);
      int i;
      @(posedge clk21m);
      ioctl_index    <= {10'd0, index};
      ioctl_download <= 1'b1;
      for (i = 0; i < n; i++) begin
         @(posedge clk21m);
         ioctl_wr   <= 1'b1;
         ioctl_addr <= `IOCTL_ADDR_W'(i);
         ioctl_dout <= data[i];
         @(posedge clk21m);
         ioctl_wr <= 1'b0;
      end
      repeat (2) @(posedge clk21m);
      ioctl_download <= 1'b0;
   endtask

   task automatic set_motor(input logic on);
      @(posedge clk21m);
      cas_motor_n <= ~on;
   endtask

   task automatic pulse_rewind();
      @(posedge clk21m);
      rewind_req <= 1'b1;
      @(posedge clk21m);
      rewind_req <= 1'b0;
   endtask

   // Leading 0 bit of byte 0 after the high idle level
   task automatic wait_fall(input int limit);
      int n;
      n = 0;
      @(negedge clk21m);
      while ((cas_audio_in !== 1'b0) && (n < limit)) begin
         @(negedge clk21m);
         n++;
      end
      if (cas_audio_in !== 1'b0) begin
         $display("No falling edge on cas_audio_in within %0d cycles", limit);
         err_cnt++;
      end
   endtask

   // Sample mid-slot, optional 100 cycle motor stop after bit pause_at
   task automatic play_bits(input int nbits, input int pause_at);
      int k;
      for (k = 0; k < nbits; k++) begin
         repeat ((k == 0) ? 16 : 32) @(negedge clk21m);
         check_val($sformatf("cas_audio_in bit %0d", k), cas_audio_in, image_bit(k));
         if (k == pause_at) begin
            @(posedge clk21m);
            cas_motor_n <= 1'b1;
            repeat (100) begin
               @(negedge clk21m);
               check_val("cas_audio_in paused", cas_audio_in, image_bit(k));
            end
            @(posedge clk21m);
            cas_motor_n <= 1'b0;
         end
      end
   endtask

   task automatic hold_high(input int skip, input int n);
      repeat (skip) @(negedge clk21m);
      repeat (n) begin
         @(negedge clk21m);
         check_val("cas_audio_in idle", cas_audio_in, 1);
      end
   endtask

   task automatic report_result(input string name, input int start);
      if (err_cnt == start) begin
         pass_cnt++;
         $display("%s: ok", name);
      end else begin
         fail_cnt++;
         $display("%s: FAIL, %0d errors", name, err_cnt - start);
      end
   endtask

   //==========================================================================
   // Tests
   //==========================================================================

   task automatic test_reset_state();
      int start;
      start = err_cnt;
      set_motor(1'b1);
      hold_high(0, 64);
      report_result("reset_state", start);
   endtask

   task automatic test_load_play();
      int start;
      start = err_cnt;
      set_motor(1'b0);
      download_image(6'd`CAS_IOCTL_INDEX, img_a, 16);
      exp_img = img_a;
      set_motor(1'b1);
      wait_fall(200);
      play_bits(128, -1);
      hold_high(20, 64);
      report_result("load_and_play", start);
   endtask

   task automatic test_other_index();
      int start;
      start = err_cnt;
      set_motor(1'b0);
      download_image(6'd3, img_b, 16);
      pulse_rewind();
      set_motor(1'b1);
      wait_fall(200);
      play_bits(128, -1);
      hold_high(20, 64);
      report_result("other_index", start);
   endtask

   task automatic test_pause();
      int start;
      start = err_cnt;
      set_motor(1'b0);
      pulse_rewind();
      set_motor(1'b1);
      wait_fall(200);
      // Stop lands in byte 4, bit 4
      play_bits(128, 36);
      hold_high(20, 64);
      report_result("pause_resume", start);
   endtask

   task automatic test_rewind_reload();
      int start;
      start = err_cnt;
      set_motor(1'b0);
      pulse_rewind();
      set_motor(1'b1);
      wait_fall(200);
      play_bits(44, -1);
      // Rewind with the motor still running
      pulse_rewind();
      @(negedge clk21m);
      check_val("cas_audio_in rewound", cas_audio_in, 1);
      wait_fall(200);
      play_bits(32, -1);
      // Shorter image replaces the first one
      set_motor(1'b0);
      download_image(6'd`CAS_IOCTL_INDEX, img_c, 8);
      exp_img = img_c;
      set_motor(1'b1);
      wait_fall(200);
      play_bits(64, -1);
      hold_high(20, 64);
      report_result("rewind_reload", start);
   endtask

   task automatic test_adc_source();
      int start;
      int c;
      start = err_cnt;
      @(posedge clk21m);
      audio_src <= CAS_AUDIO_ADC;
      for (c = 0; c < 4; c++) begin
         @(posedge clk21m);
         tape_adc     <= c[0];
         tape_adc_act <= c[1];
         @(negedge clk21m);
         check_val("cas_audio_in adc", cas_audio_in, c[0] & c[1]);
      end
      @(posedge clk21m);
      audio_src    <= CAS_AUDIO_FILE;
      tape_adc     <= 1'b0;
      tape_adc_act <= 1'b0;
      report_result("adc_source", start);
   endtask

   //==========================================================================
   // Main sequence
   //==========================================================================

   initial begin
      logic [31:0] rnd;
      seed           = 32'hebfa_84f2;
      rst_n          = 1'b0;
      ioctl_download = 1'b0;
      ioctl_index    = 16'd0;
      ioctl_wr       = 1'b0;
      ioctl_addr     = '0;
      ioctl_dout     = 8'd0;
      rewind_req     = 1'b0;
      cas_motor_n    = 1'b1;
      audio_src      = CAS_AUDIO_FILE;
      tape_adc       = 1'b0;
      tape_adc_act   = 1'b0;

      for (int i = 0; i < 16; i++) begin
         rnd      = $random(seed);
         img_a[i] = rnd[7:0];
         rnd      = $random(seed);
         img_b[i] = rnd[7:0];
         rnd      = $random(seed);
         img_c[i] = rnd[7:0];
      end
      // Leading 0 marks the first bit
      img_a[0] = 8'h7F;
      img_c[0] = 8'h7F;
      exp_img  = img_a;

      repeat (4) @(posedge clk21m);
      rst_n <= 1'b1;

      test_reset_state();
      test_load_play();
      test_other_index();
      test_pause();
      test_rewind_reload();
      test_adc_source();

      $display("Summary: %0d tests ok, %0d tests bad, %0d check errors",
               pass_cnt, fail_cnt, err_cnt);
      if ((fail_cnt == 0) && (err_cnt == 0)) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

// File: msx_cas_top.f
+incdir+.
cas_mem_pkg.sv
tape_pkg.sv
cas_loader.sv
cas_buffer.sv
tape_player.sv
msx_cas_top.sv
tb_msx_cas_top.sv

// File: Makefile
VERILATOR := verilator
TOP       := tb_msx_cas_top
DUT_TOP   := msx_cas_top
FILELIST  := msx_cas_top.f
VFLAGS    := --binary --timing --assert -Wno-fatal --timescale 1ns/10ps
LINTFLAGS := --lint-only --timing -Wall --timescale 1ns/10ps
PASS_MSG  := test passed

SRCS := $(filter-out +%,$(shell cat $(FILELIST))) msx_cas_consts.svh

.PHONY: all build run lint clean

all: run

build: obj_dir/V$(TOP)

obj_dir/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
